// ==== Bender.yml ====
package:
  name: jtag_tap

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tap_pkg.sv
      - rtl/jtag_reg_pkg.sv
      - rtl/tap_fsm.sv
      - rtl/tap_ir.sv
      - rtl/tap_dr.sv
      - rtl/jtag_tap_top.sv
  - target: simulation
    include_dirs:
      - rtl
      - sim
    files:
      - sim/jtag_tap_tb.sv

// ==== rtl/jtag_defines.svh ====
`ifndef JTAG_DEFINES_SVH
`define JTAG_DEFINES_SVH

// Register lengths
`define IR_LEN   4
`define USER_LEN 32

// Value loaded into the IR in Capture-IR, low bits fixed at 01 by 1149.1
`define IR_CAPTURE 4'b0101

// Instruction codes
`define INSTR_IDCODE 4'd1
`define INSTR_USER   4'd8
`define INSTR_BYPASS 4'd15

// IDCODE fields
`define IDCODE_VERSION 4'h2
`define IDCODE_PART    16'hb41f
`define IDCODE_MANUF   11'h37a

`endif

// ==== rtl/jtag_reg_pkg.sv ====
`include "jtag_defines.svh"

package jtag_reg_pkg;

  typedef enum logic [`IR_LEN-1:0] {
    IDCODE = `INSTR_IDCODE,
    USER   = `INSTR_USER,
    BYPASS = `INSTR_BYPASS
  } instr_e;

  // Field layout of the 1149.1 device identification word
  typedef struct packed {
    logic [3:0]  version;
    logic [15:0] part;
    logic [10:0] manuf;
    logic        one;   // Always 1, marks an IDCODE in a chain
  } idcode_fields_t;

  // The register shifts the raw word while its value is built field by field
  typedef union packed {
    logic [31:0]    raw;
    idcode_fields_t f;
  } idcode_u;

endpackage

// ==== rtl/jtag_tap_top.sv ====
`timescale 1ns/1ns
`include "jtag_defines.svh"

module jtag_tap_top (
  input  logic                 TCK,
  input  logic                 TRST,
  input  logic                 tms,
  input  logic                 tdi,
  output logic                 tdo,
  output logic                 tdo_en,
  output logic [`USER_LEN-1:0] user_data,
  output tap_pkg::tap_state_e  tap_state
);

  jtag_reg_pkg::instr_e instr;
  logic                 ir_so;
  logic                 ir_shifting;

  tap_fsm u_tap_fsm (
    .TCK   (TCK),
    .TRST  (TRST),
    .tms   (tms),
    .state (tap_state)
  );

  // Instruction path
  tap_ir u_tap_ir (
    .TCK         (TCK),
    .TRST        (TRST),
    .state       (tap_state),
    .tdi         (tdi),
    .instr       (instr),
    .ir_so       (ir_so),
    .ir_shifting (ir_shifting)
  );

  // Data registers, also owns the TDO pin flop
  tap_dr u_tap_dr (
    .TCK         (TCK),
    .TRST        (TRST),
    .state       (tap_state),
    .instr       (instr),
    .tdi         (tdi),
    .ir_so       (ir_so),
    .ir_shifting (ir_shifting),
    .tdo         (tdo),
    .tdo_en      (tdo_en),
    .user_data   (user_data)
  );

endmodule

// ==== rtl/tap_dr.sv ====
`timescale 1ns/1ns
`include "jtag_defines.svh"

module tap_dr (
  input  logic                  TCK,
  input  logic                  TRST,
  input  tap_pkg::tap_state_e   state,
  input  jtag_reg_pkg::instr_e  instr,
  input  logic                  tdi,
  input  logic                  ir_so,
  input  logic                  ir_shifting,
  output logic                  tdo,
  output logic                  tdo_en,
  output logic [`USER_LEN-1:0]  user_data
);

  jtag_reg_pkg::idcode_u idcode;

  logic                 bypass_reg;
  logic [`USER_LEN-1:0] dr_sr;     // Shared by IDCODE and USER
  logic                 dr_shifting;
  logic                 dr_long;
  logic                 dr_so;

  always_comb begin
    idcode.f = '{
      version: `IDCODE_VERSION,
      part:    `IDCODE_PART,
      manuf:   `IDCODE_MANUF,
      one:     1'b1
    };
  end

  assign dr_shifting = (state == tap_pkg::SHIFT_DR);

  // High when instr routes the 32-bit register rather than the bypass bit
  assign dr_long = (instr == jtag_reg_pkg::IDCODE) || (instr == jtag_reg_pkg::USER);
  assign dr_so   = dr_long ? dr_sr[0] : bypass_reg;

  always_ff @(posedge TCK) begin
    if (state == tap_pkg::CAPTURE_DR) begin
      bypass_reg <= 1'b0;
    end else if (dr_shifting) begin
      bypass_reg <= tdi;
    end
  end

  always_ff @(posedge TCK) begin
    if (state == tap_pkg::CAPTURE_DR) begin
      if (instr == jtag_reg_pkg::USER) begin
        dr_sr <= user_data;   // Readback of the last update
      end else begin
        dr_sr <= idcode.raw;
      end
    end else if (dr_shifting && dr_long) begin
      dr_sr <= {tdi, dr_sr[`USER_LEN-1:1]};
    end
  end

  // USER shadow register, written half a cycle into Update-DR
  always_ff @(negedge TCK or negedge TRST) begin
    if (!TRST) begin
      user_data <= '0;
    end else if (state == tap_pkg::UPDATE_DR && instr == jtag_reg_pkg::USER) begin
      user_data <= dr_sr;
    end
  end

  // The single TDO flop for both scan paths
  always_ff @(negedge TCK or negedge TRST) begin
    if (!TRST) begin
      tdo    <= 1'b0;
      tdo_en <= 1'b0;
    end else begin
      tdo_en <= ir_shifting || dr_shifting;
      if (ir_shifting) begin
        tdo <= ir_so;
      end else if (dr_shifting) begin
        tdo <= dr_so;
      end
    end
  end

endmodule

// ==== rtl/tap_fsm.sv ====
`timescale 1ns/1ns

module tap_fsm (
  input  logic                TCK,
  input  logic                TRST,
  input  logic                tms,
  output tap_pkg::tap_state_e state
);

  tap_pkg::tap_state_e next_state;

  always_ff @(posedge TCK or negedge TRST) begin
    if (!TRST) begin
      state <= tap_pkg::TEST_LOGIC_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      tap_pkg::TEST_LOGIC_RESET:
        next_state = tms ? tap_pkg::TEST_LOGIC_RESET : tap_pkg::RUN_TEST_IDLE;
      tap_pkg::RUN_TEST_IDLE:
        next_state = tms ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;

      tap_pkg::SELECT_DR_SCAN:
        next_state = tms ? tap_pkg::SELECT_IR_SCAN : tap_pkg::CAPTURE_DR;
      tap_pkg::CAPTURE_DR:
        next_state = tms ? tap_pkg::EXIT1_DR : tap_pkg::SHIFT_DR;
      tap_pkg::SHIFT_DR:
        next_state = tms ? tap_pkg::EXIT1_DR : tap_pkg::SHIFT_DR;
      tap_pkg::EXIT1_DR:
        next_state = tms ? tap_pkg::UPDATE_DR : tap_pkg::PAUSE_DR;
      tap_pkg::PAUSE_DR:
        next_state = tms ? tap_pkg::EXIT2_DR : tap_pkg::PAUSE_DR;
      tap_pkg::EXIT2_DR:
        next_state = tms ? tap_pkg::UPDATE_DR : tap_pkg::SHIFT_DR;
      tap_pkg::UPDATE_DR:
        next_state = tms ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;

      // Leaving Select-IR with TMS high is the last step of the five-cycle reset
      tap_pkg::SELECT_IR_SCAN:
        next_state = tms ? tap_pkg::TEST_LOGIC_RESET : tap_pkg::CAPTURE_IR;
      tap_pkg::CAPTURE_IR:
        next_state = tms ? tap_pkg::EXIT1_IR : tap_pkg::SHIFT_IR;
      tap_pkg::SHIFT_IR:
        next_state = tms ? tap_pkg::EXIT1_IR : tap_pkg::SHIFT_IR;
      tap_pkg::EXIT1_IR:
        next_state = tms ? tap_pkg::UPDATE_IR : tap_pkg::PAUSE_IR;
      tap_pkg::PAUSE_IR:
        next_state = tms ? tap_pkg::EXIT2_IR : tap_pkg::PAUSE_IR;
      tap_pkg::EXIT2_IR:
        next_state = tms ? tap_pkg::UPDATE_IR : tap_pkg::SHIFT_IR;
      tap_pkg::UPDATE_IR:
        next_state = tms ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;

      default:
        next_state = tap_pkg::TEST_LOGIC_RESET;
    endcase
  end

endmodule

// ==== rtl/tap_ir.sv ====
`timescale 1ns/1ns
`include "jtag_defines.svh"

module tap_ir (
  input  logic                  TCK,
  input  logic                  TRST,
  input  tap_pkg::tap_state_e   state,
  input  logic                  tdi,
  output jtag_reg_pkg::instr_e  instr,
  output logic                  ir_so,
  output logic                  ir_shifting
);

  logic [`IR_LEN-1:0] ir_sr;

  assign ir_shifting = (state == tap_pkg::SHIFT_IR);
  assign ir_so       = ir_sr[0];

  // Capture and shift on the rising edge
  always_ff @(posedge TCK) begin
    if (state == tap_pkg::CAPTURE_IR) begin
      ir_sr <= `IR_CAPTURE;
    end else if (ir_shifting) begin
      ir_sr <= {tdi, ir_sr[`IR_LEN-1:1]};   // LSB leaves first
    end
  end

  // The update latch runs on the falling edge so instr is stable for the next rising edge
  always_ff @(negedge TCK or negedge TRST) begin
    if (!TRST) begin
      instr <= jtag_reg_pkg::IDCODE;
    end else if (state == tap_pkg::TEST_LOGIC_RESET) begin
      instr <= jtag_reg_pkg::IDCODE;
    end else if (state == tap_pkg::UPDATE_IR) begin
      case (ir_sr)
        `INSTR_IDCODE: instr <= jtag_reg_pkg::IDCODE;
        `INSTR_USER:   instr <= jtag_reg_pkg::USER;
        default:       instr <= jtag_reg_pkg::BYPASS;   // Undecoded codes fall back to bypass
      endcase
    end
  end

endmodule

// ==== rtl/tap_pkg.sv ====
package tap_pkg;

  // Encoding follows the usual TAP numbering, DR branch before IR branch
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET = 4'h0,
    RUN_TEST_IDLE    = 4'h1,
    SELECT_DR_SCAN   = 4'h2,
    CAPTURE_DR       = 4'h3,
    SHIFT_DR         = 4'h4,
    EXIT1_DR         = 4'h5,
    PAUSE_DR         = 4'h6,
    EXIT2_DR         = 4'h7,
    UPDATE_DR        = 4'h8,
    SELECT_IR_SCAN   = 4'h9,
    CAPTURE_IR       = 4'ha,
    SHIFT_IR         = 4'hb,
    EXIT1_IR         = 4'hc,
    PAUSE_IR         = 4'hd,
    EXIT2_IR         = 4'he,
    UPDATE_IR        = 4'hf
  } tap_state_e;

endpackage

// ==== sim/jtag_tap_tasks.svh ====
`ifndef JTAG_TAP_TASKS_SVH
`define JTAG_TAP_TASKS_SVH

task automatic fail_run(input string reason);
  $display("%s", reason);
  $display("Errors found");
  $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    fail_run($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                       $time, name, expected, actual));
  end
endtask

// One TCK cycle; tdo_v is the bit shown on tdo while this edge shifts
task automatic clock_tms(input logic tms_v, input logic tdi_v, output logic tdo_v);
  logic exp_en;
  @(negedge TCK);
  tms = tms_v;
  tdi = tdi_v;
  exp_en = (model_state == tap_pkg::SHIFT_IR) || (model_state == tap_pkg::SHIFT_DR);
  model_state = next_tap_state(model_state, tms_v);
  @(posedge TCK);
  #4;   // Just before the next falling edge
  check_value("tap_state", model_state, tap_state);
  check_value("tdo_en", exp_en, tdo_en);
  tdo_v = tdo;
endtask

task automatic wait_for_state(input tap_pkg::tap_state_e target, input logic tms_v,
                              input int limit, input string what);
  int   n;
  logic unused;
  n = 0;
  while (tap_state !== target && n < limit) begin
    clock_tms(tms_v, 1'b0, unused);
    n++;
  end
  if (tap_state !== target) begin
    fail_run($sformatf("Gave up after %0d TCK cycles waiting for %s", limit, what));
  end
endtask

task automatic apply_reset(input int cycles);
  @(negedge TCK);
  TRST = 1'b0;
  tms  = 1'b1;
  tdi  = 1'b0;
  #1;
  check_value("tap_state", tap_pkg::TEST_LOGIC_RESET, tap_state);   // Must not wait for TCK
  check_value("tdo_en", 1'b0, tdo_en);
  check_value("tdo", 1'b0, tdo);
  check_value("user_data", 32'h0, user_data);
  repeat (cycles) @(negedge TCK);
  TRST = 1'b1;
  model_state = tap_pkg::TEST_LOGIC_RESET;
endtask

// Full scan from Run-Test/Idle back to Run-Test/Idle
task automatic scan(input logic is_ir, input int nbits, input logic [31:0] din,
                    input int pause_at, output logic [31:0] dout);
  logic bit_out;
  logic unused;
  dout = '0;
  clock_tms(1'b1, 1'b0, unused);
  if (is_ir) begin
    clock_tms(1'b1, 1'b0, unused);
  end
  clock_tms(1'b0, 1'b0, unused);   // Capture
  clock_tms(1'b0, 1'b0, unused);   // Enter Shift
  for (int i = 0; i < nbits; i++) begin
    clock_tms((i == nbits - 1) || (i == pause_at), din[i], bit_out);
    dout[i] = bit_out;
    if (i == pause_at && i != nbits - 1) begin
      clock_tms(1'b0, 1'b0, unused);   // Pause
      clock_tms(1'b0, 1'b0, unused);
      clock_tms(1'b1, 1'b0, unused);   // Exit2
      clock_tms(1'b0, 1'b0, unused);   // Back to Shift
    end
  end
  clock_tms(1'b1, 1'b0, unused);       // Update
  wait_for_state(tap_pkg::RUN_TEST_IDLE, 1'b0, 1, "Run-Test/Idle after an update");
endtask

task automatic load_instruction(input logic [`IR_LEN-1:0] code, output logic [31:0] captured);
  scan(1'b1, `IR_LEN, {{(32-`IR_LEN){1'b0}}, code}, -1, captured);
endtask

`endif

// ==== sim/jtag_tap_tb.sv ====
`timescale 1ns/1ns
`include "jtag_defines.svh"

module jtag_tap_tb;

  localparam int NUM_ROWS = 12;

  // Row kinds of the stimulus table
  localparam logic [3:0] ROW_WALK      = 4'd0;
  localparam logic [3:0] ROW_TMS_RESET = 4'd1;
  localparam logic [3:0] ROW_TRST      = 4'd2;
  localparam logic [3:0] ROW_IR        = 4'd3;
  localparam logic [3:0] ROW_IDCODE    = 4'd4;
  localparam logic [3:0] ROW_BYPASS    = 4'd5;
  localparam logic [3:0] ROW_USER      = 4'd6;

  // For USER rows arg[3:0] is the code and arg[15:8] the bit after which the scan pauses
  typedef struct packed {
    logic [3:0]  kind;
    logic [31:0] arg;
    logic [31:0] data;
    logic [31:0] expected;
  } row_t;

  logic                 TCK = 1'b0;
  logic                 TRST;
  logic                 tms;
  logic                 tdi;
  logic                 tdo;
  logic                 tdo_en;
  logic [`USER_LEN-1:0] user_data;
  tap_pkg::tap_state_e  tap_state;

  tap_pkg::tap_state_e  model_state;   // Expected state, follows the 1149.1 rule
  row_t                 rows [NUM_ROWS];

  jtag_tap_top DUT (
    .TCK       (TCK),
    .TRST      (TRST),
    .tms       (tms),
    .tdi       (tdi),
    .tdo       (tdo),
    .tdo_en    (tdo_en),
    .user_data (user_data),
    .tap_state (tap_state)
  );

  always #5 TCK = ~TCK;

  function automatic tap_pkg::tap_state_e next_tap_state(input tap_pkg::tap_state_e s,
                                                         input logic t);
    case (s)
      tap_pkg::TEST_LOGIC_RESET: next_tap_state = t ? s : tap_pkg::RUN_TEST_IDLE;
      tap_pkg::RUN_TEST_IDLE:    next_tap_state = t ? tap_pkg::SELECT_DR_SCAN : s;
      tap_pkg::SELECT_DR_SCAN:   next_tap_state = t ? tap_pkg::SELECT_IR_SCAN : tap_pkg::CAPTURE_DR;
      tap_pkg::SELECT_IR_SCAN:   next_tap_state = t ? tap_pkg::TEST_LOGIC_RESET : tap_pkg::CAPTURE_IR;
      tap_pkg::CAPTURE_DR:       next_tap_state = t ? tap_pkg::EXIT1_DR : tap_pkg::SHIFT_DR;
      tap_pkg::SHIFT_DR:         next_tap_state = t ? tap_pkg::EXIT1_DR : s;
      tap_pkg::EXIT1_DR:         next_tap_state = t ? tap_pkg::UPDATE_DR : tap_pkg::PAUSE_DR;
      tap_pkg::PAUSE_DR:         next_tap_state = t ? tap_pkg::EXIT2_DR : s;
      tap_pkg::EXIT2_DR:         next_tap_state = t ? tap_pkg::UPDATE_DR : tap_pkg::SHIFT_DR;
      tap_pkg::CAPTURE_IR:       next_tap_state = t ? tap_pkg::EXIT1_IR : tap_pkg::SHIFT_IR;
      tap_pkg::SHIFT_IR:         next_tap_state = t ? tap_pkg::EXIT1_IR : s;
      tap_pkg::EXIT1_IR:         next_tap_state = t ? tap_pkg::UPDATE_IR : tap_pkg::PAUSE_IR;
      tap_pkg::PAUSE_IR:         next_tap_state = t ? tap_pkg::EXIT2_IR : s;
      tap_pkg::EXIT2_IR:         next_tap_state = t ? tap_pkg::UPDATE_IR : tap_pkg::SHIFT_IR;
      default:                   next_tap_state = t ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;
    endcase
  endfunction

  `include "jtag_tap_tasks.svh"

  task automatic build_table();
    jtag_reg_pkg::idcode_u id;
    logic [31:0]           w1;
    logic [31:0]           w2;
    logic [31:0]           w3;
    logic [31:0]           b1;
    logic [31:0]           b2;
    id.f.version = `IDCODE_VERSION;
    id.f.part    = `IDCODE_PART;
    id.f.manuf   = `IDCODE_MANUF;
    id.f.one     = 1'b1;
    w1 = $urandom;
    w2 = $urandom;
    w3 = $urandom;
    b1 = $urandom;
    b2 = $urandom;
    // 24 TMS bits, LSB first, that pass through all sixteen states
    rows[0]  = '{ROW_WALK, 32'h00ef_d3d2, 32'd24, 32'h0000_ffff};
    rows[1]  = '{ROW_TMS_RESET, 32'd16, $urandom, 32'(tap_pkg::TEST_LOGIC_RESET)};
    rows[2]  = '{ROW_TMS_RESET, 32'd16, $urandom, 32'(tap_pkg::TEST_LOGIC_RESET)};
    rows[3]  = '{ROW_TMS_RESET, 32'd16, $urandom, 32'(tap_pkg::TEST_LOGIC_RESET)};
    rows[4]  = '{ROW_TRST, 32'd9, $urandom, 32'(tap_pkg::TEST_LOGIC_RESET)};
    rows[5]  = '{ROW_IR, 32'h6, 32'h0, 32'(`IR_CAPTURE)};
    rows[6]  = '{ROW_IDCODE, 32'h0, $urandom, id.raw};
    rows[7]  = '{ROW_BYPASS, 32'(`INSTR_BYPASS), b1, {b1[30:0], 1'b0}};
    rows[8]  = '{ROW_BYPASS, 32'h3, b2, {b2[30:0], 1'b0}};   // Undecoded code
    rows[9]  = '{ROW_USER, {16'h0, 8'hff, 8'(`INSTR_USER)}, w1, 32'h0};
    rows[10] = '{ROW_USER, {16'h0, 8'd13, 8'(`INSTR_USER)}, w2, w1};
    rows[11] = '{ROW_USER, {16'h0, 8'd20, 8'(`INSTR_USER)}, w3, w2};
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] dout;
    logic [15:0] visited;
    logic        unused;
    int          pause_at;
    case (r.kind)
      ROW_WALK: begin
        visited = '0;
        visited[tap_state] = 1'b1;
        for (int i = 0; i < r.data; i++) begin
          clock_tms(r.arg[i], 1'b0, unused);
          visited[tap_state] = 1'b1;
        end
        check_value("visited states", r.expected, visited);
      end
      ROW_TMS_RESET: begin
        for (int i = 0; i < r.arg; i++) begin
          clock_tms(r.data[i], r.data[31-i], unused);
        end
        repeat (5) begin
          clock_tms(1'b1, 1'b0, unused);
        end
        check_value("tap_state", r.expected, tap_state);
      end
      ROW_TRST: begin
        wait_for_state(tap_pkg::RUN_TEST_IDLE, 1'b0, 2, "Run-Test/Idle");
        clock_tms(1'b1, 1'b0, unused);
        clock_tms(1'b0, 1'b0, unused);
        clock_tms(1'b0, 1'b0, unused);   // Now in Shift-DR
        for (int i = 0; i < r.arg; i++) begin
          clock_tms(1'b0, r.data[i], unused);
        end
        apply_reset(2);
        check_value("tap_state", r.expected, tap_state);
      end
      ROW_IDCODE: begin
        wait_for_state(tap_pkg::TEST_LOGIC_RESET, 1'b1, 5, "Test-Logic-Reset");
        wait_for_state(tap_pkg::RUN_TEST_IDLE, 1'b0, 2, "Run-Test/Idle");
        scan(1'b0, 32, r.data, -1, dout);
        check_value("tdo idcode word", r.expected, dout);
      end
      default: begin
        wait_for_state(tap_pkg::RUN_TEST_IDLE, 1'b0, 2, "Run-Test/Idle");
        load_instruction(r.arg[`IR_LEN-1:0], dout);
        check_value("tdo ir capture", `IR_CAPTURE, dout);
        if (r.kind == ROW_BYPASS) begin
          scan(1'b0, 32, r.data, -1, dout);
          check_value("tdo bypass word", r.expected, dout);
        end else if (r.kind == ROW_USER) begin
          pause_at = (r.arg[15:8] == 8'hff) ? -1 : int'(r.arg[15:8]);
          scan(1'b0, `USER_LEN, r.data, pause_at, dout);
          check_value("tdo user readback", r.expected, dout);
          check_value("user_data", r.data, user_data);
        end
      end
    endcase
  endtask

  initial begin
    TRST        = 1'b0;
    tms         = 1'b1;
    tdi         = 1'b0;
    model_state = tap_pkg::TEST_LOGIC_RESET;
    void'($urandom(91467));
    build_table();
    apply_reset(8);
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
+incdir+sim
rtl/tap_pkg.sv
rtl/jtag_reg_pkg.sv
rtl/tap_fsm.sv
rtl/tap_ir.sv
rtl/tap_dr.sv
rtl/jtag_tap_top.sv
sim/jtag_tap_tb.sv
